// ==== logic/dai_consts.svh ====
// Audio sample-buffer peripheral constants
// Widths, bus region nibbles and status register offsets

`ifndef DAI_CONSTS_SVH
`define DAI_CONSTS_SVH

// Ring index width, sets both buffer depths
`define DAI_PTR_W 6
`define DAI_DEPTH (1 << `DAI_PTR_W)

// Audio sample and bus widths
`define DAI_SAMPLE_W 24
`define DAI_WORD_W 32
`define DAI_ADDR_W 16

// Region nibbles in address bits 15 to 12
`define DAI_REGION_RX_WIN 4'hF
`define DAI_REGION_TX_WIN 4'hE
`define DAI_REGION_STAT 4'hD

// Status register offsets in the low address byte
`define DAI_OFS_RX_STAT 8'h00
`define DAI_OFS_TX_STAT 8'h01

`endif

// ==== logic/dai_pkg.sv ====
// Audio sample-buffer peripheral types
// Vector typedefs, decoded bus command and bus FSM states

`include "dai_consts.svh"

package dai_pkg;

  typedef logic [`DAI_SAMPLE_W-1:0] dai_sample_t;
  typedef logic [`DAI_PTR_W-1:0] dai_ptr_t;
  typedef logic [`DAI_WORD_W-1:0] dai_word_t;
  typedef logic [`DAI_ADDR_W-1:0] dai_addr_t;

  // One decoded bus access, valid for a single cycle
  typedef struct packed {
    logic valid;
    logic we;
    // Address class flags
    logic rx_win;
    logic tx_win;
    logic rx_stat;
    logic tx_stat;
    // Window offset from address bits 5 to 0
    dai_ptr_t offset;
    dai_word_t wdata;
  } dai_cmd_t;

  // Decode FSM
  typedef enum logic {
    BUS_IDLE,
    BUS_ACK
  } dai_bus_state_e;

endpackage

// ==== logic/dai_bus_decode.sv ====
// Wishbone classic slave front end
// Accepts one request at a time and emits a one-cycle decoded command

`timescale 1ns/1ps
`include "dai_consts.svh"

module dai_bus_decode
  import dai_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      wb_cyc_i,
  input  logic      wb_stb_i,
  input  logic      wb_we_i,
  input  dai_addr_t wb_adr_i,
  input  dai_word_t wb_dat_i,
  output dai_cmd_t  cmd_o
);

  dai_bus_state_e state_q;
  dai_cmd_t       cmd_q;
  logic           accept;
  logic [3:0]     region;
  logic [7:0]     low_byte;

  assign region   = wb_adr_i[15:12];
  assign low_byte = wb_adr_i[7:0];
  assign accept   = (state_q == BUS_IDLE) && wb_cyc_i && wb_stb_i;

  // BUS_ACK covers the command cycle and the ack cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= BUS_IDLE;
    end else begin
      case (state_q)
        BUS_IDLE: if (accept) state_q <= BUS_ACK;
        // Command pulse gone, so ack is out this cycle
        BUS_ACK:  if (!cmd_q.valid) state_q <= BUS_IDLE;
        default:  state_q <= BUS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q.we      <= wb_we_i;
      cmd_q.rx_win  <= (region == `DAI_REGION_RX_WIN);
      cmd_q.tx_win  <= (region == `DAI_REGION_TX_WIN);
      cmd_q.rx_stat <= (region == `DAI_REGION_STAT) && (low_byte == `DAI_OFS_RX_STAT);
      cmd_q.tx_stat <= (region == `DAI_REGION_STAT) && (low_byte == `DAI_OFS_TX_STAT);
      cmd_q.offset  <= wb_adr_i[`DAI_PTR_W-1:0];
      cmd_q.wdata   <= wb_dat_i;
    end
    if (rst) begin
      cmd_q.valid <= 1'b0;
    end else begin
      cmd_q.valid <= accept;
    end
  end

  assign cmd_o = cmd_q;

endmodule

// ==== logic/dai_rx_ring.sv ====
// Receive sample ring
// Stores every strobed sample, tracks unread count and the window base

`timescale 1ns/1ps
`include "dai_consts.svh"

module dai_rx_ring
  import dai_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  dai_cmd_t    cmd_i,
  input  dai_sample_t rx_data_i,
  input  logic        rx_ack_i,
  output dai_word_t   rdata_o
);

  dai_sample_t ring_mem [`DAI_DEPTH];
  dai_ptr_t    wr_ptr_q;
  dai_ptr_t    base_q;
  dai_ptr_t    unread_q;
  dai_ptr_t    rd_idx;
  logic        shift;

  // Status write consumes one sample
  assign shift  = cmd_i.valid && cmd_i.we && cmd_i.rx_stat;
  assign rd_idx = base_q + cmd_i.offset;

  always_ff @(posedge clk) begin
    if (rx_ack_i) begin
      ring_mem[wr_ptr_q] <= rx_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      base_q   <= '0;
      unread_q <= '0;
    end else begin
      if (rx_ack_i) begin
        wr_ptr_q <= wr_ptr_q + dai_ptr_t'(1);
      end
      if (shift) begin
        base_q <= base_q + dai_ptr_t'(1);
      end
      // Arrival and consume together leave unread as is
      case ({shift, rx_ack_i})
        2'b10:   unread_q <= unread_q - dai_ptr_t'(1);
        2'b01:   unread_q <= unread_q + dai_ptr_t'(1);
        default: unread_q <= unread_q;
      endcase
    end
  end

  always_comb begin
    if (cmd_i.rx_win) begin
      rdata_o = dai_word_t'(ring_mem[rd_idx]);
    end else if (cmd_i.rx_stat) begin
      rdata_o = dai_word_t'(unread_q);
    end else begin
      rdata_o = '0;
    end
  end

endmodule

// ==== logic/dai_tx_queue.sv ====
// Transmit sample queue
// Filled from the bus, popped by the audio port with a registered ack

`timescale 1ns/1ps
`include "dai_consts.svh"

module dai_tx_queue
  import dai_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  dai_cmd_t    cmd_i,
  input  logic        tx_pop_i,
  output dai_sample_t tx_data_o,
  output logic        tx_ack_o,
  output dai_word_t   rdata_o
);

  dai_sample_t tx_mem [`DAI_DEPTH];
  dai_ptr_t    wr_ptr_q;
  dai_ptr_t    last_rd_q;
  dai_ptr_t    count_q;
  dai_ptr_t    win_idx;
  logic        ack_q;
  logic        full;
  logic        enq;
  logic        pop;

  // One slot stays unused, so 63 entries at most
  assign full = (count_q == dai_ptr_t'(`DAI_DEPTH - 1));
  assign enq  = cmd_i.valid && cmd_i.we && cmd_i.tx_stat && !full;
  assign pop  = tx_pop_i && (count_q != '0);

  // Window counts back from the newest write
  assign win_idx = wr_ptr_q - dai_ptr_t'(1) - cmd_i.offset;

  always_ff @(posedge clk) begin
    if (enq) begin
      tx_mem[wr_ptr_q] <= cmd_i.wdata[`DAI_SAMPLE_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q  <= '0;
      last_rd_q <= '1;
      count_q   <= '0;
      ack_q     <= 1'b0;
    end else begin
      ack_q <= tx_pop_i;
      if (enq) begin
        wr_ptr_q <= wr_ptr_q + dai_ptr_t'(1);
      end
      if (pop) begin
        last_rd_q <= last_rd_q + dai_ptr_t'(1);
      end
      case ({enq, pop})
        2'b10:   count_q <= count_q + dai_ptr_t'(1);
        2'b01:   count_q <= count_q - dai_ptr_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  assign tx_data_o = tx_mem[last_rd_q];
  assign tx_ack_o  = ack_q;

  always_comb begin
    if (cmd_i.tx_win) begin
      rdata_o = dai_word_t'(tx_mem[win_idx]);
    end else if (cmd_i.tx_stat) begin
      rdata_o = dai_word_t'(count_q);
    end else begin
      rdata_o = '0;
    end
  end

endmodule

// ==== logic/dai_read_result.sv ====
// Read result stage
// Picks the read word of the addressed buffer and registers it with the ack

`timescale 1ns/1ps

module dai_read_result
  import dai_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  dai_cmd_t  cmd_i,
  input  dai_word_t rx_rdata_i,
  input  dai_word_t tx_rdata_i,
  output dai_word_t wb_dat_o,
  output logic      wb_ack_o
);

  dai_word_t rdata_sel;
  dai_word_t rdata_q;
  logic      ack_q;

  // Writes and unmapped reads return zero
  always_comb begin
    if (!cmd_i.we && (cmd_i.rx_win || cmd_i.rx_stat)) begin
      rdata_sel = rx_rdata_i;
    end else if (!cmd_i.we && (cmd_i.tx_win || cmd_i.tx_stat)) begin
      rdata_sel = tx_rdata_i;
    end else begin
      rdata_sel = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_i.valid) begin
      rdata_q <= rdata_sel;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= cmd_i.valid;
    end
  end

  assign wb_dat_o = rdata_q;
  assign wb_ack_o = ack_q;

endmodule

// ==== logic/dai_top.sv ====
// Audio sample-buffer peripheral top level
// Wishbone decode, receive ring, transmit queue and read result stage

`timescale 1ns/1ps

module dai_top
  import dai_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  // Wishbone slave
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  dai_addr_t   wb_adr_i,
  input  dai_word_t   wb_dat_i,
  output dai_word_t   wb_dat_o,
  output logic        wb_ack_o,
  // Audio port
  input  dai_sample_t rx_data_i,
  input  logic        rx_ack_i,
  input  logic        tx_pop_i,
  output dai_sample_t tx_data_o,
  output logic        tx_ack_o
);

  dai_cmd_t  cmd;
  dai_word_t rx_rdata;
  dai_word_t tx_rdata;

  dai_bus_decode dai_bus_decode_inst (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .cmd_o    (cmd)
  );

  dai_rx_ring dai_rx_ring_inst (
    .clk       (clk),
    .rst       (rst),
    .cmd_i     (cmd),
    .rx_data_i (rx_data_i),
    .rx_ack_i  (rx_ack_i),
    .rdata_o   (rx_rdata)
  );

  dai_tx_queue dai_tx_queue_inst (
    .clk       (clk),
    .rst       (rst),
    .cmd_i     (cmd),
    .tx_pop_i  (tx_pop_i),
    .tx_data_o (tx_data_o),
    .tx_ack_o  (tx_ack_o),
    .rdata_o   (tx_rdata)
  );

  dai_read_result dai_read_result_inst (
    .clk        (clk),
    .rst        (rst),
    .cmd_i      (cmd),
    .rx_rdata_i (rx_rdata),
    .tx_rdata_i (tx_rdata),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o)
  );

endmodule

// ==== dv/tb_clk_gen.sv ====
// Testbench clock source
// Free-running clock with a fixed period

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 10
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

// ==== dv/tb_dai_checker.sv ====
// Reference model and scoreboard for the audio sample-buffer peripheral
// Rebuilds bus decode, receive ring and transmit queue from port activity
// and compares every bus read and the audio outputs

`timescale 1ns/1ps
`include "dai_consts.svh"

module tb_dai_checker
  import dai_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  dai_addr_t   wb_adr_i,
  input  dai_word_t   wb_dat_i,
  input  dai_word_t   wb_rdata_i,
  input  logic        wb_ack_i,
  input  dai_sample_t rx_data_i,
  input  logic        rx_ack_i,
  input  logic        tx_pop_i,
  input  dai_sample_t tx_sample_i,
  input  logic        tx_ack_i,
  output int unsigned checks_o,
  output int unsigned bus_errors_o,
  output int unsigned audio_errors_o
);

  localparam int       DEPTH  = `DAI_DEPTH;
  localparam dai_ptr_t TX_MAX = dai_ptr_t'(`DAI_DEPTH - 1);

  // Shadow receive ring
  dai_sample_t rx_mem [DEPTH];
  logic        rx_known [DEPTH];
  dai_ptr_t    rx_wr;
  dai_ptr_t    rx_base;
  dai_ptr_t    rx_unread;
  // Shadow transmit queue
  dai_sample_t tx_mem [DEPTH];
  logic        tx_known [DEPTH];
  dai_ptr_t    tx_wr;
  dai_ptr_t    tx_last;
  dai_ptr_t    tx_count;
  // Request in flight and the outputs it should produce
  dai_cmd_t    cmd;
  logic        busy;
  logic        exp_ack;
  logic        exp_known;
  dai_word_t   exp_dat;
  logic        exp_tx_ack;

  int unsigned checks = 0;
  int unsigned bus_errors = 0;
  int unsigned audio_errors = 0;

  task automatic clear_model();
    for (int i = 0; i < DEPTH; i++) begin
      rx_known[i] = 1'b0;
      tx_known[i] = 1'b0;
    end
    rx_wr      = '0;
    rx_base    = '0;
    rx_unread  = '0;
    tx_wr      = '0;
    tx_last    = '1;
    tx_count   = '0;
    cmd        = '0;
    busy       = 1'b0;
    exp_ack    = 1'b0;
    exp_known  = 1'b1;
    exp_dat    = '0;
    exp_tx_ack = 1'b0;
  endtask

  task automatic compare_outputs();
    checks++;
    if (wb_ack_i !== exp_ack) begin
      bus_errors++;
      $display("ERROR %0t: wb_ack_o is %b, expected %b", $time, wb_ack_i, exp_ack);
    end else if (exp_ack && exp_known && (wb_rdata_i !== exp_dat)) begin
      bus_errors++;
      $display("ERROR %0t: wb_dat_o is %h, expected %h", $time, wb_rdata_i, exp_dat);
    end
    if (tx_ack_i !== exp_tx_ack) begin
      audio_errors++;
      $display("ERROR %0t: tx_ack_o is %b, expected %b", $time, tx_ack_i, exp_tx_ack);
    end
    // Port shows the entry at the last-read pointer
    if (tx_known[tx_last] && (tx_sample_i !== tx_mem[tx_last])) begin
      audio_errors++;
      $display("ERROR %0t: tx_data_o is %h, expected %h", $time, tx_sample_i, tx_mem[tx_last]);
    end
  endtask

  // Read word from the state before this edge's updates
  task automatic predict_read();
    dai_ptr_t idx;
    exp_dat   = '0;
    exp_known = 1'b1;
    if (cmd.valid && !cmd.we) begin
      if (cmd.rx_win) begin
        idx       = rx_base + cmd.offset;
        exp_dat   = dai_word_t'(rx_mem[idx]);
        exp_known = rx_known[idx];
      end else if (cmd.rx_stat) begin
        exp_dat = dai_word_t'(rx_unread);
      end else if (cmd.tx_win) begin
        // Newest write first
        idx       = tx_wr - dai_ptr_t'(1) - cmd.offset;
        exp_dat   = dai_word_t'(tx_mem[idx]);
        exp_known = tx_known[idx];
      end else if (cmd.tx_stat) begin
        exp_dat = dai_word_t'(tx_count);
      end
    end
  endtask

  task automatic apply_updates();
    logic shift;
    logic enq;
    logic pop;
    shift = cmd.valid && cmd.we && cmd.rx_stat;
    enq   = cmd.valid && cmd.we && cmd.tx_stat && (tx_count != TX_MAX);
    pop   = tx_pop_i && (tx_count != '0);
    if (rx_ack_i) begin
      rx_mem[rx_wr]   = rx_data_i;
      rx_known[rx_wr] = 1'b1;
      rx_wr           = rx_wr + dai_ptr_t'(1);
    end
    if (shift) begin
      rx_base = rx_base + dai_ptr_t'(1);
    end
    // Unread wraps at 64 and holds when a sample lands with a consume
    if (shift && !rx_ack_i) begin
      rx_unread = rx_unread - dai_ptr_t'(1);
    end else if (rx_ack_i && !shift) begin
      rx_unread = rx_unread + dai_ptr_t'(1);
    end
    if (enq) begin
      tx_mem[tx_wr]   = cmd.wdata[`DAI_SAMPLE_W-1:0];
      tx_known[tx_wr] = 1'b1;
      tx_wr           = tx_wr + dai_ptr_t'(1);
    end
    if (pop) begin
      tx_last = tx_last + dai_ptr_t'(1);
    end
    if (enq && !pop) begin
      tx_count = tx_count + dai_ptr_t'(1);
    end else if (pop && !enq) begin
      tx_count = tx_count - dai_ptr_t'(1);
    end
  endtask

  always @(posedge clk) begin
    logic accept;
    if (rst) begin
      clear_model();
    end else begin
      compare_outputs();
      // A new request is taken only once the previous ack is out
      accept = !busy && wb_cyc_i && wb_stb_i;
      if (exp_ack) begin
        busy = 1'b0;
      end
      exp_ack    = cmd.valid;
      exp_tx_ack = tx_pop_i;
      predict_read();
      apply_updates();
      cmd.valid = accept;
      if (accept) begin
        busy        = 1'b1;
        cmd.we      = wb_we_i;
        cmd.rx_win  = (wb_adr_i[15:12] == `DAI_REGION_RX_WIN);
        cmd.tx_win  = (wb_adr_i[15:12] == `DAI_REGION_TX_WIN);
        cmd.rx_stat = (wb_adr_i[15:12] == `DAI_REGION_STAT) && (wb_adr_i[7:0] == 8'h00);
        cmd.tx_stat = (wb_adr_i[15:12] == `DAI_REGION_STAT) && (wb_adr_i[7:0] == 8'h01);
        cmd.offset  = wb_adr_i[`DAI_PTR_W-1:0];
        cmd.wdata   = wb_dat_i;
      end
    end
  end

  assign checks_o       = checks;
  assign bus_errors_o   = bus_errors;
  assign audio_errors_o = audio_errors;

endmodule

// ==== dv/tb_dai_top.sv ====
// Testbench top for the audio sample-buffer peripheral
// Drives random Wishbone traffic and audio strobes into the DUT

`timescale 1ns/1ps
`include "dai_consts.svh"

module tb_dai_top
  import dai_pkg::*;
();

  localparam int unsigned NUM_TRANS      = 2000;
  localparam int unsigned TIMEOUT_CYCLES = NUM_TRANS * 4 + 200;

  logic        clk;
  logic        rst;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  dai_addr_t   wb_adr_i;
  dai_word_t   wb_dat_i;
  dai_word_t   wb_dat_o;
  logic        wb_ack_o;
  dai_sample_t rx_data_i;
  logic        rx_ack_i;
  logic        tx_pop_i;
  dai_sample_t tx_data_o;
  logic        tx_ack_o;
  logic        audio_on;
  logic        heavy_pop;
  int unsigned checks;
  int unsigned bus_errors;
  int unsigned audio_errors;
  int unsigned cycle_count = 0;

  tb_clk_gen #(.PERIOD_NS(10)) clk_gen_inst (.clk_o(clk));

  dai_top dai_top_inst (.*);

  tb_dai_checker checker_inst (
    .*,
    .wb_rdata_i     (wb_dat_o),
    .wb_ack_i       (wb_ack_o),
    .tx_sample_i    (tx_data_o),
    .tx_ack_i       (tx_ack_o),
    .checks_o       (checks),
    .bus_errors_o   (bus_errors),
    .audio_errors_o (audio_errors)
  );

  // Advance one clock and drive the next audio strobes
  task automatic step_cycle();
    @(posedge clk);
    if (audio_on) begin
      rx_ack_i  <= ($urandom_range(3, 0) == 0);
      rx_data_i <= dai_sample_t'($urandom());
      // Rare pops first so the queue fills, frequent pops later to drain it
      tx_pop_i  <= ($urandom_range(heavy_pop ? 3 : 127, 0) == 0);
    end
  endtask

  task automatic bus_transfer(input logic we, input dai_addr_t adr, input dai_word_t dat);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    do begin
      step_cycle();
    end while (wb_ack_o !== 1'b1);
  endtask

  task automatic random_transfer();
    int unsigned kind;
    logic        we;
    dai_addr_t   adr;
    kind = $urandom_range(11, 0);
    we   = 1'($urandom());
    adr  = dai_addr_t'($urandom());
    case (kind)
      0, 1, 2: adr[15:12] = `DAI_REGION_RX_WIN;
      3, 4:    adr = {`DAI_REGION_STAT, 4'h0, `DAI_OFS_RX_STAT};
      5, 6, 7: adr = {`DAI_REGION_STAT, 4'h0, `DAI_OFS_TX_STAT};
      8, 9:    adr[15:12] = `DAI_REGION_TX_WIN;
      10:      adr[15:12] = 4'($urandom_range(12, 0));
      // Region D past the two status registers
      default: begin
        adr[15:12] = `DAI_REGION_STAT;
        adr[7:0]   = 8'($urandom_range(255, 2));
      end
    endcase
    bus_transfer(we, adr, dai_word_t'($urandom()));
  endtask

  initial begin
    rst       = 1'b1;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    rx_data_i = '0;
    rx_ack_i  = 1'b0;
    tx_pop_i  = 1'b0;
    audio_on  = 1'b0;
    heavy_pop = 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    // Both counts straight out of reset
    bus_transfer(1'b0, {`DAI_REGION_STAT, 4'h0, `DAI_OFS_RX_STAT}, '0);
    bus_transfer(1'b0, {`DAI_REGION_STAT, 4'h0, `DAI_OFS_TX_STAT}, '0);
    void'($urandom(32'h847c));
    audio_on = 1'b1;
    for (int n = 0; n < NUM_TRANS; n++) begin
      heavy_pop = (n >= NUM_TRANS / 2);
      random_transfer();
      // Either back to back or one idle cycle
      if ($urandom_range(1, 0) == 0) begin
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        step_cycle();
      end
    end
    audio_on = 1'b0;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    rx_ack_i <= 1'b0;
    tx_pop_i <= 1'b0;
    repeat (3) @(posedge clk);
    $display("Checks %0d, bus errors %0d, audio errors %0d", checks, bus_errors, audio_errors);
    if ((bus_errors == 0) && (audio_errors == 0)) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  always @(posedge clk) begin
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end else begin
      cycle_count <= cycle_count + 1;
    end
  end

endmodule

// ==== files.f ====
+incdir+logic
logic/dai_pkg.sv
logic/dai_bus_decode.sv
logic/dai_rx_ring.sv
logic/dai_tx_queue.sv
logic/dai_read_result.sv
logic/dai_top.sv
dv/tb_clk_gen.sv
dv/tb_dai_checker.sv
dv/tb_dai_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the audio buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_dai_top -o tb_dai_top > build.log 2>&1 \
  && ./obj_dir/tb_dai_top > sim.log 2>&1 \
  && grep -qx ">>> PASS" sim.log \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

echo "Simulation passed"
